// File: files.f
+incdir+verification
verilog/pet_pkg.sv
verilog/display_pkg.sv
verilog/tick_gen.sv
verilog/button_capture.sv
verilog/mode_select.sv
verilog/need_bank.sv
verilog/status_display.sv
verilog/pet_top.sv
verification/tb_pet_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it, exit status carries the result
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -j 0 --top-module tb_pet_top -f files.f -o sim_pet &&
    ./obj_dir/sim_pet || exit 1

// File: verification/pet_vectors.svh
`ifndef PET_VECTORS_SVH
`define PET_VECTORS_SVH

// Columns: buttons, lights_on, held ticks, idle ticks min and max,
// then expected sel_need, shown level, face_happy and test_led
typedef struct packed {
    logic [5:0]      btn;                         // Bit order of the B_ masks
    logic            lights;
    int              hold;                        // Ticks the buttons stay down
    int              idle_min;                    // Released ticks before next row
    int              idle_max;
    pet_pkg::need_e  sel;
    pet_pkg::level_t level;
    logic            face;
    logic            led;
} vec_t;

localparam logic [5:0] B_NONE    = 6'b000000;
localparam logic [5:0] B_HEALTH  = 6'b000001;
localparam logic [5:0] B_ENERGY  = 6'b000010;
localparam logic [5:0] B_HUNGER  = 6'b000100;
localparam logic [5:0] B_FUN     = 6'b001000;
localparam logic [5:0] B_RESTART = 6'b010000;
localparam logic [5:0] B_TEST    = 6'b100000;

localparam int NUM_VECS = 25;

// Idle ranges wider than one tick only where the levels cannot move
localparam vec_t VECTORS [NUM_VECS] = '{
    '{B_NONE,            1'b1, 0,  1, 1, pet_pkg::NEED_HEALTH, 4'd8,  1'b1, 1'b0}, // Reset
    '{B_HUNGER,          1'b1, 1,  1, 1, pet_pkg::NEED_HUNGER, 4'd8,  1'b1, 1'b0}, // Select only
    '{B_HUNGER,          1'b1, 1,  1, 1, pet_pkg::NEED_HUNGER, 4'd9,  1'b1, 1'b0}, // Feed
    '{B_HUNGER,          1'b1, 1,  1, 1, pet_pkg::NEED_HUNGER, 4'd9,  1'b1, 1'b0}, // Tick 5 decay
    '{B_HUNGER,          1'b1, 1,  1, 1, pet_pkg::NEED_HUNGER, 4'd10, 1'b1, 1'b0},
    '{B_HUNGER,          1'b1, 1,  1, 1, pet_pkg::NEED_HUNGER, 4'd10, 1'b1, 1'b0}, // Feed beats decay
    '{B_HEALTH | B_FUN,  1'b1, 1,  1, 1, pet_pkg::NEED_HEALTH, 4'd4,  1'b0, 1'b0}, // Priority
    '{B_NONE,            1'b1, 2,  1, 1, pet_pkg::NEED_HEALTH, 4'd3,  1'b0, 1'b0}, // Every 3 ticks
    '{B_NONE,            1'b1, 11, 1, 1, pet_pkg::NEED_HEALTH, 4'd0,  1'b0, 1'b0}, // Floor at 0
    '{B_FUN,             1'b1, 1,  1, 1, pet_pkg::NEED_FUN,    4'd4,  1'b0, 1'b0},
    '{B_NONE,            1'b1, 5,  1, 1, pet_pkg::NEED_FUN,    4'd3,  1'b0, 1'b0}, // Every 7 ticks
    '{B_HUNGER,          1'b1, 1,  1, 1, pet_pkg::NEED_HUNGER, 4'd5,  1'b1, 1'b0},
    '{B_NONE,            1'b1, 2,  1, 1, pet_pkg::NEED_HUNGER, 4'd4,  1'b0, 1'b0}, // Turns sad
    '{B_ENERGY,          1'b1, 1,  1, 1, pet_pkg::NEED_ENERGY, 4'd8,  1'b1, 1'b0},
    '{B_ENERGY,          1'b1, 1,  1, 1, pet_pkg::NEED_ENERGY, 4'd9,  1'b1, 1'b0}, // Lit feed
    '{B_NONE,            1'b0, 3,  1, 1, pet_pkg::NEED_ENERGY, 4'd9,  1'b1, 1'b0}, // Dark, no step yet
    '{B_NONE,            1'b0, 4,  1, 1, pet_pkg::NEED_ENERGY, 4'd10, 1'b1, 1'b0}, // Rise then cap
    '{B_NONE,            1'b1, 8,  1, 3, pet_pkg::NEED_ENERGY, 4'd10, 1'b1, 1'b0}, // No decay lit
    '{B_TEST,            1'b1, 1,  1, 3, pet_pkg::NEED_ENERGY, 4'd10, 1'b1, 1'b1},
    '{B_ENERGY,          1'b1, 1,  1, 3, pet_pkg::NEED_ENERGY, 4'd1,  1'b0, 1'b1}, // 10 to 1
    '{B_HUNGER,          1'b1, 1,  1, 3, pet_pkg::NEED_HUNGER, 4'd1,  1'b0, 1'b1}, // 0 to 1
    '{B_NONE,            1'b1, 10, 1, 3, pet_pkg::NEED_HUNGER, 4'd1,  1'b0, 1'b1}, // Frozen
    '{B_HUNGER,          1'b1, 1,  1, 3, pet_pkg::NEED_HUNGER, 4'd10, 1'b1, 1'b1}, // 1 to 10
    '{B_RESTART,         1'b1, 1,  1, 1, pet_pkg::NEED_HEALTH, 4'd8,  1'b1, 1'b0},
    '{B_NONE,            1'b1, 2,  1, 1, pet_pkg::NEED_HEALTH, 4'd7,  1'b1, 1'b0}  // Timers cleared
};

`endif

// File: verification/tb_pet_top.sv
`timescale 1ns/100ps

module tb_pet_top;

    localparam int TICK_DIV       = 4;
    localparam int DECAY_HEALTH   = 3;
    localparam int DECAY_HUNGER   = 5;
    localparam int DECAY_FUN      = 7;
    localparam int RECOVER_ENERGY = 4;
    localparam int CLK_PERIOD     = 20;           // ns
    localparam int unsigned SEED  = 32'hd17abd11;

    `include "pet_vectors.svh"

    logic              clk;
    logic              reset;
    logic              btn_health;
    logic              btn_energy;
    logic              btn_hunger;
    logic              btn_fun;
    logic              btn_restart;
    logic              btn_test;
    logic              lights_on;
    display_pkg::seg_t seg;
    logic              face_happy;
    pet_pkg::need_e    sel_need;
    logic              test_led;

    pet_top #(
        .TICK_DIV      (TICK_DIV),
        .DECAY_HEALTH  (DECAY_HEALTH),
        .DECAY_HUNGER  (DECAY_HUNGER),
        .DECAY_FUN     (DECAY_FUN),
        .RECOVER_ENERGY(RECOVER_ENERGY)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .btn_health (btn_health),
        .btn_energy (btn_energy),
        .btn_hunger (btn_hunger),
        .btn_fun    (btn_fun),
        .btn_restart(btn_restart),
        .btn_test   (btn_test),
        .lights_on  (lights_on),
        .seg        (seg),
        .face_happy (face_happy),
        .sel_need   (sel_need),
        .test_led   (test_led)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_seg(input display_pkg::seg_t got, input display_pkg::seg_t exp,
                             input int row);
        if (got !== exp) begin
            abort_run($sformatf("mismatch seg row %0d: got %h expected %h", row, got, exp));
        end
    endtask

    task automatic check_need(input pet_pkg::need_e got, input pet_pkg::need_e exp,
                              input int row);
        if (got !== exp) begin
            abort_run($sformatf("mismatch sel_need row %0d: got %h expected %h",
                                row, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name,
                              input int row);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s row %0d: got %h expected %h",
                                name, row, got, exp));
        end
    endtask

    task automatic drive_buttons(input logic [5:0] btn);
        btn_health  <= btn[0];
        btn_energy  <= btn[1];
        btn_hunger  <= btn[2];
        btn_fun     <= btn[3];
        btn_restart <= btn[4];
        btn_test    <= btn[5];
    endtask

    // Entered on an edge that lines up with the tick phase
    task automatic apply_row(input int idx);
        vec_t        row;
        int unsigned span;
        int          idle;
        row = VECTORS[idx];
        drive_buttons(row.btn);
        lights_on <= row.lights;
        repeat (row.hold * TICK_DIV) @(posedge clk);   // Last held tick edge
        repeat (2) @(posedge clk);                     // Display registered one cycle after tick
        check_need(sel_need, row.sel, idx);
        check_seg(seg, display_pkg::seg_encode(row.level), idx);
        check_flag(face_happy, row.face, "face_happy", idx);
        check_flag(test_led, row.led, "test_led", idx);
        drive_buttons(B_NONE);                         // Release so the next press is an edge
        span = row.idle_max - row.idle_min + 1;
        idle = row.idle_min + int'($urandom % span);
        repeat (idle * TICK_DIV - 2) @(posedge clk);   // Back in tick phase
    endtask

    function automatic int total_ticks();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_VECS; i++) begin
            sum += VECTORS[i].hold + VECTORS[i].idle_max;
        end
        return sum;
    endfunction

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        btn_health  = 1'b0;
        btn_energy  = 1'b0;
        btn_hunger  = 1'b0;
        btn_fun     = 1'b0;
        btn_restart = 1'b0;
        btn_test    = 1'b0;
        lights_on   = 1'b1;
        void'($urandom(SEED));                         // One seed for the whole run
        repeat (3) @(posedge clk);
        reset <= 1'b0;                                 // Tick counter starts here
        for (int i = 0; i < NUM_VECS; i++) begin
            apply_row(i);
        end
        $display("=== PASS ===");
        $finish;
    end

    // Twice the longest possible table run
    initial begin
        longint limit_ns;
        limit_ns = longint'(total_ticks()) * TICK_DIV * CLK_PERIOD * 2;
        #(limit_ns);
        abort_run($sformatf("run timed out after %0d ns", limit_ns));
    end

endmodule

// File: verilog/button_capture.sv
`timescale 1ns/100ps

module button_capture (
    input  logic       clk,
    input  logic       reset,
    input  logic       tick,
    input  logic       btn_health,
    input  logic       btn_energy,
    input  logic       btn_hunger,
    input  logic       btn_fun,
    input  logic       btn_restart,
    input  logic       btn_test,
    output logic [3:0] press_need,                // Indexed by need_e
    output logic       press_restart,
    output logic       press_test
);

    logic [5:0] btn_raw;                          // Async button inputs
    logic [5:0] sync1;                            // First sync stage
    logic [5:0] sync2;                            // Second sync stage
    logic [5:0] sync3;                            // Delayed copy for edges
    logic [5:0] rise;                             // Rising edge strobes
    logic [5:0] pend;                             // Sticky presses

    assign btn_raw = {btn_test, btn_restart, btn_fun, btn_hunger, btn_energy, btn_health};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync1 <= '0;
            sync2 <= '0;
            sync3 <= '0;
        end else begin
            sync1 <= btn_raw;
            sync2 <= sync1;
            sync3 <= sync2;
        end
    end

    assign rise = sync2 & ~sync3;

    // Held through the tick cycle, then dropped
    // An edge landing on the tick itself carries to the next tick
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pend <= '0;
        end else if (tick) begin
            pend <= rise;                         // Consumed this tick
        end else begin
            pend <= pend | rise;                  // Repeats merge
        end
    end

    assign press_need    = pend[3:0];
    assign press_restart = pend[4];
    assign press_test    = pend[5];

endmodule

// File: verilog/display_pkg.sv
package display_pkg;

    typedef logic [6:0] seg_t;                    // Segment a in bit 0, g in bit 6

    localparam seg_t SEG_BLANK = 7'b0000000;      // All segments dark

    // Level to seven-segment pattern, active high segments
    function automatic seg_t seg_encode(input pet_pkg::level_t level);
        seg_t pattern;
        case (level)
            4'd0:    pattern = 7'b0111111;        // 0
            4'd1:    pattern = 7'b0000110;        // 1
            4'd2:    pattern = 7'b1011011;        // 2
            4'd3:    pattern = 7'b1001111;        // 3
            4'd4:    pattern = 7'b1100110;        // 4
            4'd5:    pattern = 7'b1101101;        // 5
            4'd6:    pattern = 7'b1111101;        // 6
            4'd7:    pattern = 7'b0000111;        // 7
            4'd8:    pattern = 7'b1111111;        // 8
            4'd9:    pattern = 7'b1101111;        // 9
            4'd10:   pattern = 7'b1110111;        // Letter A stands for ten
            default: pattern = SEG_BLANK;         // Out of range
        endcase
        return pattern;
    endfunction

endpackage

// File: verilog/mode_select.sv
`timescale 1ns/100ps

module mode_select (
    input  logic           clk,
    input  logic           reset,
    input  logic           tick,
    input  logic [3:0]     press_need,
    input  logic           press_restart,
    input  logic           press_test,
    output pet_pkg::cmd_e  cmd,
    output pet_pkg::need_e cmd_need,
    output pet_pkg::need_e sel_need,
    output logic           test_mode
);

    pet_pkg::need_e pick;                         // Winning pressed need
    logic           any_need;                     // Some need button pressed
    logic           test_eff;                     // Test mode incl. this tick's press

    always_comb begin
        if (press_need[0]) begin
            pick = pet_pkg::NEED_HEALTH;
        end else if (press_need[1]) begin
            pick = pet_pkg::NEED_ENERGY;
        end else if (press_need[2]) begin
            pick = pet_pkg::NEED_HUNGER;
        end else begin
            pick = pet_pkg::NEED_FUN;             // Also the idle value
        end
    end

    assign any_need = |press_need;
    assign test_eff = test_mode | press_test;
    assign cmd_need = pick;

    always_comb begin
        cmd = pet_pkg::CMD_NONE;
        if (tick) begin
            if (press_restart) begin
                cmd = pet_pkg::CMD_RESTART;       // Beats everything
            end else if (any_need) begin
                if (test_eff) begin
                    cmd = pet_pkg::CMD_TOGGLE;
                end else if (pick == sel_need) begin
                    cmd = pet_pkg::CMD_FEED;      // Second press feeds
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            test_mode <= 1'b0;
            sel_need  <= pet_pkg::NEED_HEALTH;
        end else if (tick) begin
            if (press_restart) begin
                test_mode <= 1'b0;
                sel_need  <= pet_pkg::NEED_HEALTH;
            end else begin
                if (press_test) begin
                    test_mode <= 1'b1;            // Sticky until restart
                end
                if (any_need) begin
                    sel_need <= pick;
                end
            end
        end
    end

    // need_bank applies any command it sees, so idle cycles must stay quiet
    cmd_on_tick: assert property (@(posedge clk) disable iff (reset)
        !tick |-> cmd == pet_pkg::CMD_NONE)
        else $error("command outside tick");

endmodule

// File: verilog/need_bank.sv
`timescale 1ns/100ps

module need_bank #(
    parameter int DECAY_HEALTH   = 120,           // Ticks per health step down
    parameter int DECAY_HUNGER   = 70,
    parameter int DECAY_FUN      = 50,
    parameter int RECOVER_ENERGY = 100            // Ticks per energy step up
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            tick,
    input  pet_pkg::cmd_e   cmd,
    input  pet_pkg::need_e  cmd_need,
    input  logic            test_mode,
    input  logic            lights_on,
    output pet_pkg::level_t level_health,
    output pet_pkg::level_t level_energy,
    output pet_pkg::level_t level_hunger,
    output pet_pkg::level_t level_fun
);

    // Period per need, ordered like need_e
    localparam int PERIOD [4] = '{DECAY_HEALTH, RECOVER_ENERGY, DECAY_HUNGER, DECAY_FUN};
    localparam int P_HE  = (DECAY_HEALTH > RECOVER_ENERGY) ? DECAY_HEALTH : RECOVER_ENERGY;
    localparam int P_HF  = (DECAY_HUNGER > DECAY_FUN) ? DECAY_HUNGER : DECAY_FUN;
    localparam int P_MAX = (P_HE > P_HF) ? P_HE : P_HF;
    localparam int T_W   = $clog2(P_MAX + 1);     // Fits the longest period
    localparam int ENERGY = int'(pet_pkg::NEED_ENERGY);

    pet_pkg::level_t level_q [4];                 // Current levels
    pet_pkg::level_t level_d [4];
    logic [T_W-1:0]  timer_q [4];                 // Ticks into current period
    logic [T_W-1:0]  timer_d [4];
    logic [3:0]      run;                         // Timer advances this cycle
    logic [3:0]      wrap;                        // Timer event this cycle
    logic [3:0]      cmd_hit;                     // Command targets this need

    function automatic pet_pkg::level_t sat_inc(input pet_pkg::level_t lvl);
        return (lvl >= pet_pkg::LEVEL_MAX) ? pet_pkg::LEVEL_MAX : lvl + 4'd1;
    endfunction

    function automatic pet_pkg::level_t sat_dec(input pet_pkg::level_t lvl);
        return (lvl == 4'd0) ? 4'd0 : lvl - 4'd1;
    endfunction

    function automatic pet_pkg::level_t flip(input pet_pkg::level_t lvl);
        return (lvl == pet_pkg::LEVEL_TEST_LOW) ? pet_pkg::LEVEL_MAX : pet_pkg::LEVEL_TEST_LOW;
    endfunction

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            // Energy timer only runs in the dark
            run[i]     = tick && !test_mode && (i != ENERGY || !lights_on);
            wrap[i]    = run[i] && (timer_q[i] == T_W'(PERIOD[i] - 1));
            cmd_hit[i] = (int'(cmd_need) == i) &&
                         ((cmd == pet_pkg::CMD_FEED && (i != ENERGY || lights_on)) ||
                          cmd == pet_pkg::CMD_TOGGLE);
            level_d[i] = level_q[i];
            timer_d[i] = timer_q[i];
            if (cmd == pet_pkg::CMD_RESTART) begin
                level_d[i] = pet_pkg::LEVEL_INIT;
                timer_d[i] = '0;
            end else begin
                if (run[i]) begin
                    timer_d[i] = wrap[i] ? '0 : timer_q[i] + 1'b1;
                end
                if (cmd_hit[i]) begin             // Command beats timer
                    level_d[i] = (cmd == pet_pkg::CMD_TOGGLE) ? flip(level_q[i])
                                                              : sat_inc(level_q[i]);
                end else if (wrap[i]) begin
                    level_d[i] = (i == ENERGY) ? sat_inc(level_q[i]) : sat_dec(level_q[i]);
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                level_q[i] <= pet_pkg::LEVEL_INIT;
                timer_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                level_q[i] <= level_d[i];
                timer_q[i] <= timer_d[i];
            end
        end
    end

    assign level_health = level_q[pet_pkg::NEED_HEALTH];
    assign level_energy = level_q[pet_pkg::NEED_ENERGY];
    assign level_hunger = level_q[pet_pkg::NEED_HUNGER];
    assign level_fun    = level_q[pet_pkg::NEED_FUN];

    for (genvar g = 0; g < 4; g++) begin : g_chk
        // Display only encodes up to A
        level_in_range: assert property (@(posedge clk) disable iff (reset)
            level_q[g] <= pet_pkg::LEVEL_MAX)
            else $error("need %0d above max", g);

        // Levels only move on a tick
        level_hold: assert property (@(posedge clk) disable iff (reset)
            !tick |=> $stable(level_q[g]))
            else $error("need %0d changed between ticks", g);
    end

endmodule

// File: verilog/pet_pkg.sv
package pet_pkg;

    // Needs tracked by the pet, also the bit index into press vectors
    typedef enum logic [1:0] {
        NEED_HEALTH = 2'd0,                       // Top priority on a multi press
        NEED_ENERGY = 2'd1,                       // Recovers with lights off
        NEED_HUNGER = 2'd2,
        NEED_FUN    = 2'd3                        // Lowest priority
    } need_e;

    typedef logic [3:0] level_t;                  // Level 0 to 10

    localparam level_t LEVEL_MAX      = 4'd10;    // Saturation point
    localparam level_t LEVEL_INIT     = 4'd8;     // After reset or restart
    localparam level_t LEVEL_TEST_LOW = 4'd1;     // Low side of test toggle
    localparam level_t HAPPY_MIN      = 4'd5;     // Face happy from here up

    // Command from mode_select to need_bank, valid on tick only
    typedef enum logic [1:0] {
        CMD_NONE    = 2'b00,
        CMD_FEED    = 2'b01,                      // Raise one level
        CMD_TOGGLE  = 2'b10,                      // Flip between 1 and 10
        CMD_RESTART = 2'b11                       // All needs back to init
    } cmd_e;

endpackage

// File: verilog/pet_top.sv
`timescale 1ns/100ps

module pet_top #(
    parameter int TICK_DIV       = 12_500_000,    // 4 Hz tick from 50 MHz
    parameter int DECAY_HEALTH   = 120,           // Periods in ticks
    parameter int DECAY_HUNGER   = 70,
    parameter int DECAY_FUN      = 50,
    parameter int RECOVER_ENERGY = 100
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              btn_health,
    input  logic              btn_energy,
    input  logic              btn_hunger,
    input  logic              btn_fun,
    input  logic              btn_restart,
    input  logic              btn_test,
    input  logic              lights_on,          // Room lights
    output display_pkg::seg_t seg,
    output logic              face_happy,
    output pet_pkg::need_e    sel_need,
    output logic              test_led
);

    logic            tick;
    logic [3:0]      press_need;
    logic            press_restart;
    logic            press_test;
    pet_pkg::cmd_e   cmd;
    pet_pkg::need_e  cmd_need;
    pet_pkg::need_e  sel_cur;                     // Selection before display reg
    logic            test_mode;
    pet_pkg::level_t level_health;
    pet_pkg::level_t level_energy;
    pet_pkg::level_t level_hunger;
    pet_pkg::level_t level_fun;

    tick_gen #(
        .TICK_DIV(TICK_DIV)
    ) u_tick_gen (
        .clk  (clk),
        .reset(reset),
        .tick (tick)
    );

    button_capture u_button_capture (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .btn_health   (btn_health),
        .btn_energy   (btn_energy),
        .btn_hunger   (btn_hunger),
        .btn_fun      (btn_fun),
        .btn_restart  (btn_restart),
        .btn_test     (btn_test),
        .press_need   (press_need),
        .press_restart(press_restart),
        .press_test   (press_test)
    );

    mode_select u_mode_select (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .press_need   (press_need),
        .press_restart(press_restart),
        .press_test   (press_test),
        .cmd          (cmd),
        .cmd_need     (cmd_need),
        .sel_need     (sel_cur),
        .test_mode    (test_mode)
    );

    need_bank #(
        .DECAY_HEALTH  (DECAY_HEALTH),
        .DECAY_HUNGER  (DECAY_HUNGER),
        .DECAY_FUN     (DECAY_FUN),
        .RECOVER_ENERGY(RECOVER_ENERGY)
    ) u_need_bank (
        .clk         (clk),
        .reset       (reset),
        .tick        (tick),
        .cmd         (cmd),
        .cmd_need    (cmd_need),
        .test_mode   (test_mode),
        .lights_on   (lights_on),
        .level_health(level_health),
        .level_energy(level_energy),
        .level_hunger(level_hunger),
        .level_fun   (level_fun)
    );

    status_display u_status_display (
        .clk         (clk),
        .reset       (reset),
        .tick        (tick),
        .sel_need    (sel_cur),
        .test_mode   (test_mode),
        .level_health(level_health),
        .level_energy(level_energy),
        .level_hunger(level_hunger),
        .level_fun   (level_fun),
        .seg         (seg),
        .face_happy  (face_happy),
        .sel_need_q  (sel_need),
        .test_led    (test_led)
    );

endmodule

// File: verilog/status_display.sv
`timescale 1ns/100ps

module status_display (
    input  logic              clk,
    input  logic              reset,
    input  logic              tick,
    input  pet_pkg::need_e    sel_need,
    input  logic              test_mode,
    input  pet_pkg::level_t   level_health,
    input  pet_pkg::level_t   level_energy,
    input  pet_pkg::level_t   level_hunger,
    input  pet_pkg::level_t   level_fun,
    output display_pkg::seg_t seg,
    output logic              face_happy,
    output pet_pkg::need_e    sel_need_q,         // Selection aligned with seg
    output logic              test_led
);

    logic            tick_q;                      // Cycle after the tick
    pet_pkg::level_t sel_level;                   // Level of selected need

    always_comb begin
        case (sel_need)
            pet_pkg::NEED_HEALTH: sel_level = level_health;
            pet_pkg::NEED_ENERGY: sel_level = level_energy;
            pet_pkg::NEED_HUNGER: sel_level = level_hunger;
            default:              sel_level = level_fun;
        endcase
    end

    // Levels and mode settle on the tick edge, sampled one cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_q     <= 1'b0;
            seg        <= display_pkg::seg_encode(pet_pkg::LEVEL_INIT);
            face_happy <= (pet_pkg::LEVEL_INIT >= pet_pkg::HAPPY_MIN);
            sel_need_q <= pet_pkg::NEED_HEALTH;
            test_led   <= 1'b0;
        end else begin
            tick_q <= tick;
            if (tick_q) begin                     // All outputs move together
                seg        <= display_pkg::seg_encode(sel_level);
                face_happy <= (sel_level >= pet_pkg::HAPPY_MIN);
                sel_need_q <= sel_need;
                test_led   <= test_mode;
            end
        end
    end

endmodule

// File: verilog/tick_gen.sv
`timescale 1ns/100ps

module tick_gen #(
    parameter int TICK_DIV = 12_500_000           // clk cycles per tick
) (
    input  logic clk,
    input  logic reset,
    output logic tick                             // One cycle enable
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] cnt;                        // Cycles since last tick

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt <= '0;
        end else if (cnt == CNT_W'(TICK_DIV - 1)) begin
            cnt <= '0;                            // Wrap
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign tick = (cnt == CNT_W'(TICK_DIV - 1)); // Pulse on wrap

    // Downstream blocks count ticks, a stretched tick would double count
    tick_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (TICK_DIV > 1) && tick |=> !tick)
        else $error("tick lasted two cycles");

endmodule
